// File: compile.f
+incdir+verif
src/tri_inv_pkg.sv
src/fix_recip.sv
src/diag_pe.sv
src/offdiag_pe.sv
src/tri_mat_inv.sv
src/tri_inv_top.sv
verif/tri_inv_tb.sv

// File: verif/tri_inv_model.svh
// reference model of the Q16.16 triangular inverse, built from the product and reciprocal rules
`ifndef TRI_INV_MODEL_SVH
`define TRI_INV_MODEL_SVH

// floor of the full product over 2^16, kept to the low 32 bits
function automatic fix_t ref_mul(input fix_t a, input fix_t b);
    longint p;
    p = longint'(a) * longint'(b);
    return fix_t'(p >>> frac_w);
endfunction

// 2^32 / a truncated toward zero, kept to the low 32 bits
function automatic fix_t ref_recip(input fix_t a);
    longint q;
    q = (longint'(1) <<< (2 * frac_w)) / longint'(a);
    return fix_t'(q);
endfunction

// back substitution one column at a time, s sums the products above the diagonal
function automatic tri_inv_result_t ref_inverse(input tri_mat_t a);
    tri_inv_result_t res;
    fix_t            s;
    res = '0;
    if (a.a00 == '0 || a.a11 == '0 || a.a22 == '0) begin
        res.singular = 1'b1;
        return res;
    end
    res.inv.a00 = ref_recip(a.a00);
    res.inv.a11 = ref_recip(a.a11);
    res.inv.a22 = ref_recip(a.a22);
    s = ref_mul(a.a01, res.inv.a11);             // column 1
    res.inv.a01 = ref_mul(res.inv.a00, -s);
    s = ref_mul(a.a12, res.inv.a22);             // column 2, bottom up
    res.inv.a12 = ref_mul(res.inv.a11, -s);
    s = ref_mul(a.a01, res.inv.a12);
    s = s + ref_mul(a.a02, res.inv.a22);
    res.inv.a02 = ref_mul(res.inv.a00, -s);
    return res;
endfunction

`endif

// File: verif/tri_inv_tb.sv
`timescale 1ns/10ps
// table driven testbench for the triangular matrix inverse, checked against a Q16.16 model
module tri_inv_tb import tri_inv_pkg::*; ();

    localparam int   num_cases   = 9;
    localparam int   max_stall   = 5;
    localparam int   nonsing_lat = 3 * (recip_cycles + 1) + 12;
    localparam int   cycle_limit = 12 + num_cases * (nonsing_lat + max_stall + 10);
    localparam fix_t one         = 32'sh0001_0000;

    logic            clk = 1'b0;
    logic            arst_n;
    logic            in_valid;
    logic            in_ready;
    tri_mat_t        in_mat;
    logic            out_valid;
    logic            out_ready;
    tri_inv_result_t out_res;

    // element order is a00, a01, a02, a11, a12, a22
    tri_mat_t case_mat [num_cases] = '{
        '{one, 0, 0, one, 0, one},
        '{one <<< 1, 0, 0, one >>> 1, 0, -(one <<< 2)},
        '{one >>> 2, 0, 0, -(one <<< 3), 0, one <<< 4},
        '{one, one <<< 1, -3 * one, one, 4 * one, one},
        '{3 * one, 0, 0, -(3 * one) >>> 1, 0, 3 * (one >>> 2)},
        '{5 * (one >>> 2), 0, 0, 5 * (one >>> 1), 0, -5 * (one >>> 3)},
        '{one, 5 * one, one, 0, -one, one <<< 1},
        '{-7 * one, 0, 0, 32'sh0000_199A, 0, 25 * (one >>> 1)},
        '{-one, 0, one, 2 * one, 3 * one, 0}
    };
    string case_name [num_cases] = '{
        "identity", "diag_pow2_a", "diag_pow2_b", "unit_upper", "rand_a",
        "rand_b", "singular_a11", "rand_c", "singular_a22"
    };
    int        case_stall [num_cases] = '{0, 2, 0, 3, 1, 5, 0, 0, 4};
    bit        case_rand  [num_cases] = '{0, 0, 0, 0, 1, 1, 0, 1, 0};  // random off-diagonals
    int        n_checks  = 0;
    int        err_cnt   = 0;
    int        cyc_cnt   = 0;
    bit [31:0] rng_state = 32'd85852;

    `include "tri_inv_model.svh"

    tri_inv_top u_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_mat    (in_mat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_res   (out_res)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= cycle_limit) begin
            $display("timeout: the DUT did not complete the cases within %0d clock cycles",
                     cycle_limit);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic bit [31:0] xorshift32(input bit [31:0] s);
        bit [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // signed value of roughly +-8.0 from the generator state
    task automatic draw_fix(output fix_t v);
        rng_state = xorshift32(rng_state);
        v = fix_t'($signed(rng_state) >>> 12);
    endtask

    task automatic check_mat(input string name, input tri_mat_t exp_val, input tri_mat_t act);
        n_checks++;
        if (act !== exp_val) begin
            err_cnt++;
            $display("mismatch %s: expected %h, actual %h", name, exp_val, act);
        end
    endtask

    task automatic check_flag(input string name, input bit exp_val, input logic act);
        n_checks++;
        if (act !== exp_val) begin
            err_cnt++;
            $display("mismatch %s: expected %0b, actual %0b", name, exp_val, act);
        end
    endtask

    task automatic check_cycles(input string name, input int exp_val, input int act);
        n_checks++;
        if (act != exp_val) begin
            err_cnt++;
            $display("mismatch %s: expected %0d, actual %0d", name, exp_val, act);
        end
    endtask

    task automatic run_case(input int idx);
        tri_mat_t        m;
        tri_inv_result_t exp_res;
        tri_inv_result_t held;
        string           nm;
        int              lat;
        nm = case_name[idx];
        m  = case_mat[idx];
        if (case_rand[idx]) begin
            draw_fix(m.a01);
            draw_fix(m.a02);
            draw_fix(m.a12);
        end
        exp_res = ref_inverse(m);
        @(negedge clk);
        in_valid = 1'b1;
        in_mat   = m;
        while (!in_ready) begin
            @(negedge clk);
        end
        @(negedge clk);  // the matrix went in on the rising edge just passed
        in_valid = 1'b0;
        in_mat   = '0;
        lat      = 1;
        while (!out_valid) begin
            @(negedge clk);
            lat++;
        end
        check_cycles({nm, " latency"}, exp_res.singular ? 1 : nonsing_lat, lat);
        check_flag({nm, " singular"}, exp_res.singular, out_res.singular);
        check_mat({nm, " inverse"}, exp_res.inv, out_res.inv);
        held = out_res;
        repeat (case_stall[idx]) begin
            @(negedge clk);
            check_flag({nm, " stall out_valid"}, 1'b1, out_valid);
            check_flag({nm, " stall in_ready"}, 1'b0, in_ready);
            check_flag({nm, " stall singular"}, held.singular, out_res.singular);
            check_mat({nm, " stall inverse"}, held.inv, out_res.inv);
        end
        out_ready = 1'b1;
        @(negedge clk);
        out_ready = 1'b0;
        check_flag({nm, " out_valid after transfer"}, 1'b0, out_valid);
        check_flag({nm, " in_ready after transfer"}, 1'b1, in_ready);
    endtask

    initial begin
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_mat    = '0;
        out_ready = 1'b0;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_flag("reset in_ready", 1'b1, in_ready);
        check_flag("reset out_valid", 1'b0, out_valid);
        for (int i = 0; i < num_cases; i++) begin
            run_case(i);
        end
        $display("checks: %0d, errors: %0d", n_checks, err_cnt);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: src/tri_inv_top.sv
`timescale 1ns/10ps
// upper triangular matrix inverse, shared reciprocal unit in front of the systolic array
module tri_inv_top import tri_inv_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            in_valid,
    output logic            in_ready,
    input  tri_mat_t        in_mat,
    output logic            out_valid,
    input  logic            out_ready,
    output tri_inv_result_t out_res
);

    logic recip_req;
    fix_t recip_den;
    logic recip_busy;
    logic recip_done;
    fix_t recip_q;

    fix_recip u_recip (
        .clk        (clk),
        .arst_n     (arst_n),
        .recip_req  (recip_req),
        .recip_den  (recip_den),
        .recip_busy (recip_busy),
        .recip_done (recip_done),
        .recip_q    (recip_q)
    );

    tri_mat_inv u_inv (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_mat     (in_mat),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_res    (out_res),
        .recip_req  (recip_req),
        .recip_den  (recip_den),
        .recip_busy (recip_busy),
        .recip_done (recip_done),
        .recip_q    (recip_q)
    );

endmodule

// File: src/tri_mat_inv.sv
`timescale 1ns/10ps
// sequencer and systolic array that invert a 3x3 upper triangular matrix
module tri_mat_inv import tri_inv_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            in_valid,
    output logic            in_ready,
    input  tri_mat_t        in_mat,
    output logic            out_valid,
    input  logic            out_ready,
    output tri_inv_result_t out_res,
    output logic            recip_req,
    output fix_t            recip_den,
    input  logic            recip_busy,
    input  logic            recip_done,
    input  fix_t            recip_q
);

    inv_state_e       state;
    tri_mat_t         mat_r;
    tri_inv_result_t  res_r;
    logic [1:0]       recip_idx;
    logic             recip_wait;
    logic [3:0]       glb_cnt;
    fix_t [mat_n-1:0] vec_r;
    logic             in_fire;
    logic             diag_zero;
    logic [mat_n-1:0] load_r;

    fix_t z_cir [mat_n];
    fix_t z_sqr [mat_n*(mat_n-1)/2];
    fix_t x_sqr [mat_n*(mat_n-1)/2];

    assign in_ready  = (state == IDLE);
    assign out_valid = (state == OUT);
    assign out_res   = res_r;
    assign in_fire   = in_valid && in_ready;
    assign diag_zero = (in_mat.a00 == '0) || (in_mat.a11 == '0) || (in_mat.a22 == '0);
    assign recip_req = (state == RECIP) && !recip_wait;

    always_comb begin
        case (recip_idx)
            2'd0:    recip_den = mat_r.a00;
            2'd1:    recip_den = mat_r.a11;
            default: recip_den = mat_r.a22;
        endcase
    end

    // the array runs back substitution in reverse row order, so circle p holds 1/a(2-p)(2-p)
    assign load_r[0] = recip_done && (recip_idx == 2'd2);
    assign load_r[1] = recip_done && (recip_idx == 2'd1);
    assign load_r[2] = recip_done && (recip_idx == 2'd0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= IDLE;
            recip_idx  <= '0;
            recip_wait <= 1'b0;
            glb_cnt    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (in_fire) begin
                        state <= diag_zero ? OUT : RECIP;
                    end
                end
                RECIP: begin
                    if (recip_req && !recip_busy) begin
                        recip_wait <= 1'b1;
                    end
                    if (recip_done) begin
                        recip_wait <= 1'b0;
                        if (recip_idx == 2'(mat_n - 1)) begin
                            recip_idx <= '0;
                            glb_cnt   <= '0;
                            state     <= FEED;
                        end else begin
                            recip_idx <= recip_idx + 2'd1;
                        end
                    end
                end
                FEED: begin
                    glb_cnt <= glb_cnt + 4'd1;
                    if (glb_cnt == 4'(feed_len - 1)) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    glb_cnt <= glb_cnt + 4'd1;
                    if (glb_cnt == 4'(feed_len + array_depth - 1)) begin
                        state <= OUT;
                    end
                end
                OUT: begin
                    if (out_ready) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // even counts carry e0, e1, e2 and odd counts the zero bubble after each
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vec_r <= '0;
        end else begin
            vec_r <= '0;
            if (state == FEED && !glb_cnt[0]) begin
                vec_r[glb_cnt[2:1]] <= fix_one;
            end
        end
    end

    // column e0 of the array input gives column 2 of the inverse, e2 gives column 0
    always_ff @(posedge clk) begin
        if (in_fire) begin
            mat_r <= in_mat;
            res_r <= '{inv: '0, singular: diag_zero};
        end else if (state == FEED || state == DRAIN) begin
            case (glb_cnt)
                4'd4: begin
                    res_r.inv.a22 <= z_sqr[1];
                end
                4'd5: begin
                    res_r.inv.a12 <= z_sqr[2];
                end
                4'd6: begin
                    res_r.inv.a02 <= z_cir[2];
                    res_r.inv.a11 <= z_sqr[2];
                end
                4'd7: begin
                    res_r.inv.a01 <= z_cir[2];
                end
                4'd8: begin
                    res_r.inv.a00 <= z_cir[2];
                end
                default: begin
                end
            endcase
        end
    end

    // first row
    diag_pe u_cir0 (
        .clk    (clk),
        .arst_n (arst_n),
        .load_r (load_r[0]),
        .r_in   (recip_q),
        .x_in   (vec_r[0]),
        .z_out  (z_cir[0])
    );

    offdiag_pe u_sqr01 (
        .clk    (clk),
        .arst_n (arst_n),
        .a_in   (mat_r.a12),
        .x_in   (vec_r[1]),
        .z_in   (z_cir[0]),
        .x_out  (x_sqr[0]),
        .z_out  (z_sqr[0])
    );

    offdiag_pe u_sqr02 (
        .clk    (clk),
        .arst_n (arst_n),
        .a_in   (mat_r.a02),
        .x_in   (vec_r[2]),
        .z_in   (z_sqr[0]),
        .x_out  (x_sqr[1]),
        .z_out  (z_sqr[1])
    );

    // second row
    diag_pe u_cir1 (
        .clk    (clk),
        .arst_n (arst_n),
        .load_r (load_r[1]),
        .r_in   (recip_q),
        .x_in   (x_sqr[0]),
        .z_out  (z_cir[1])
    );

    offdiag_pe u_sqr12 (
        .clk    (clk),
        .arst_n (arst_n),
        .a_in   (mat_r.a01),
        .x_in   (x_sqr[1]),
        .z_in   (z_cir[1]),
        .x_out  (x_sqr[2]),
        .z_out  (z_sqr[2])
    );

    // third row
    diag_pe u_cir2 (
        .clk    (clk),
        .arst_n (arst_n),
        .load_r (load_r[2]),
        .r_in   (recip_q),
        .x_in   (x_sqr[2]),
        .z_out  (z_cir[2])
    );

    a_out_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_res))
    );

    // a new matrix is taken only after the previous result has left
    a_one_in_flight: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(in_ready) |-> $past(out_valid && out_ready)
    );

endmodule

// File: src/offdiag_pe.sv
`timescale 1ns/10ps
// square cell of the triangular array, subtracts a*z from the partial value and passes z on
module offdiag_pe import tri_inv_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    input  fix_t a_in,
    input  fix_t x_in,
    input  fix_t z_in,
    output fix_t x_out,
    output fix_t z_out
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            x_out <= '0;
            z_out <= '0;
        end else begin
            x_out <= x_in - fix_mul(a_in, z_in);
            z_out <= z_in;  // next square cell in the row sees z one cycle later
        end
    end

endmodule

// File: src/diag_pe.sv
`timescale 1ns/10ps
// circle cell of the triangular array, scales the incoming partial value by 1/a_ii
module diag_pe import tri_inv_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    input  logic load_r,
    input  fix_t r_in,
    input  fix_t x_in,
    output fix_t z_out
);

    fix_t r_q;  // stored diagonal reciprocal

    // a cleared reciprocal keeps the array free of unknowns until the first load
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            r_q <= '0;
        end else if (load_r) begin
            r_q <= r_in;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            z_out <= '0;
        end else begin
            z_out <= fix_mul(x_in, r_q);  // stands in for the divide x / a_ii
        end
    end

endmodule

// File: src/fix_recip.sv
`timescale 1ns/10ps
// fixed-point reciprocal 1/a by restoring division, one quotient bit per clock
module fix_recip import tri_inv_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    input  logic recip_req,
    input  fix_t recip_den,
    output logic recip_busy,
    output logic recip_done,
    output fix_t recip_q
);

    recip_state_e           state;
    logic [recip_cnt_w-1:0] bit_cnt;
    logic [data_w-1:0]      den_r;   // divisor magnitude
    logic [data_w-1:0]      rem_r;
    logic [data_w-1:0]      quot_r;
    logic                   neg_r;
    logic                   take;
    logic [data_w:0]        rem_sh;
    logic [data_w:0]        rem_sub;
    logic                   q_bit;

    assign recip_busy = (state != R_IDLE);
    assign recip_done = (state == R_DONE);
    assign take       = recip_req && !recip_busy;

    // the dividend is 1 << 2*frac_w, so only the first bit shifted in is a one
    assign rem_sh  = {rem_r, bit_cnt == '0};
    assign rem_sub = rem_sh - {1'b0, den_r};
    assign q_bit   = (rem_sh >= {1'b0, den_r});

    // the top quotient bit falls off quot_r, which is the 32 bit wrap
    assign recip_q = neg_r ? -fix_t'(quot_r) : fix_t'(quot_r);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= R_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                R_IDLE: begin
                    if (take) begin
                        state   <= R_BUSY;
                        bit_cnt <= '0;
                    end
                end
                R_BUSY: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == recip_cnt_w'(data_w)) begin  // data_w+1 bits in total
                        state <= R_DONE;
                    end
                end
                R_DONE: begin
                    state <= R_IDLE;
                end
                default: begin
                    state <= R_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            neg_r  <= recip_den[data_w-1];
            den_r  <= recip_den[data_w-1] ? -recip_den : recip_den;
            rem_r  <= '0;
            quot_r <= '0;
        end else if (state == R_BUSY) begin
            rem_r  <= q_bit ? rem_sub[data_w-1:0] : rem_sh[data_w-1:0];
            quot_r <= {quot_r[data_w-2:0], q_bit};
        end
    end

    // the sequencer screens zero diagonals, so a zero divisor never gets here
    a_den_nonzero: assert property (
        @(posedge clk) disable iff (!arst_n)
        take |-> (recip_den != '0)
    );

endmodule

// File: src/tri_inv_pkg.sv
// shared Q16.16 types, triangular matrix structs and FSM states for the matrix inverse
package tri_inv_pkg;

    localparam int data_w       = 32;
    localparam int frac_w       = 16;
    localparam int mat_n        = 3;
    localparam int recip_cycles = data_w + 2;   // request to done pulse
    localparam int recip_cnt_w  = $clog2(recip_cycles);
    localparam int feed_len     = 2 * mat_n;    // identity columns with their bubbles
    localparam int array_depth  = 5;            // cycles from last bubble to last harvest slot

    typedef logic signed [data_w-1:0] fix_t;

    localparam fix_t fix_one = fix_t'(1) <<< frac_w;

    // upper triangle only, the lower part is zero by definition
    typedef struct packed {
        fix_t a00;
        fix_t a01;
        fix_t a02;
        fix_t a11;
        fix_t a12;
        fix_t a22;
    } tri_mat_t;

    typedef struct packed {
        tri_mat_t inv;
        logic     singular;
    } tri_inv_result_t;

    typedef enum logic [2:0] {IDLE, RECIP, FEED, DRAIN, OUT} inv_state_e;

    typedef enum logic [1:0] {R_IDLE, R_BUSY, R_DONE} recip_state_e;

    // full product shifted down by the fraction bits, floor rounding, wrapped to 32 bits
    function automatic fix_t fix_mul(input fix_t a, input fix_t b);
        logic signed [2*data_w-1:0] prod;
        prod = a * b;
        return fix_t'(prod >>> frac_w);
    endfunction

endpackage
